// File: build.f
+incdir+include
hdl/emu_pkg.sv
hdl/emu_ctrl_if.sv
hdl/emu_sequencer.sv
hdl/emu_slice.sv
hdl/emu_status.sv
hdl/emu_top.sv
testbench/emu_ref_pkg.sv
testbench/emu_tb.sv

// File: run.sh
#!/bin/sh
# build the emulation harness testbench with verilator and run it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module emu_tb \
    -Mdir obj_dir -o emu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/emu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict on a line of its own.
if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

// File: testbench/emu_tb.sv
`timescale 1ns/1ns
`include "emu_settings.svh"

module emu_tb;
    import emu_pkg::*;
    import emu_ref_pkg::*;

    localparam int FF_LEN  = 2 * `EMU_SLICES;
    localparam int RAM_LEN = `EMU_SLICES * `EMU_RAM_DEPTH;
    localparam int BURSTS  = 4;
    localparam int MIX_LEN = 200;
    // upper bound on host cycles over all tests.
    localparam int PLANNED = 40 + 6 * (FF_LEN + 1) + 4 * (RAM_LEN + 2) + BURSTS * 17 + MIX_LEN;

    logic host_clk = 1'b0;
    logic reset, target_rst, run_mode, scan_mode, ff_scan, ff_dir;
    logic ram_scan_reset, ram_scan, ram_dir, idle;
    emu_word_t ff_sdi, ff_sdo, ram_sdi, ram_sdo;
    logic [`EMU_COUNT_WIDTH-1:0] cycle_count;

    int checks = 0;
    int errors = 0;
    emu_word_t words [$];
    emu_word_t expected [$];

    emu_top dut_i (.*);

    always #4 host_clk = ~host_clk;

    task automatic check(input string name, input emu_word_t exp_val, input emu_word_t act);
        checks++;
        if (exp_val !== act) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp_val, act);
        end
    endtask

    // model takes the edge, next inputs go out, outputs are checked at the falling edge.
    task automatic tick(input string name, input logic t_rst, input logic run, input logic scan,
                        input logic ffs, input logic rams, input logic dir, input logic rsr);
        @(posedge host_clk);
        model_step(expected_op(target_rst, run_mode, scan_mode, ff_scan, ram_scan),
                   ff_dir, ff_sdi, ram_dir, ram_sdi, scan_mode && ram_scan_reset);
        target_rst     <= t_rst;
        run_mode       <= run;
        scan_mode      <= scan;
        ff_scan        <= ffs;
        ram_scan       <= rams;
        ff_dir         <= dir;
        ram_dir        <= dir;
        ram_scan_reset <= rsr;
        ff_sdi         <= take_bits(`EMU_WORD_WIDTH);
        ram_sdi        <= take_bits(`EMU_WORD_WIDTH);
        @(negedge host_clk);
        check({name, " ff_sdo"}, emu_word_t'(m_ptr[`EMU_SLICES-1]), ff_sdo);
        check({name, " ram_sdo"}, m_mem[`EMU_SLICES-1][m_addr], ram_sdo);
        check({name, " idle"}, emu_word_t'(m_idle), emu_word_t'(idle));
        check({name, " cycle_count"}, emu_word_t'(m_count), emu_word_t'(cycle_count));
    endtask

    task automatic scan_ff(input string name, input logic dir);
        words.delete();
        for (int j = 0; j < FF_LEN; j++) begin
            tick(name, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, dir, 1'b0);
            words.push_back(ff_sdo);  // head before shift j.
        end
        tick(name, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic scan_ram(input string name, input logic dir);
        tick(name, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        words.delete();
        for (int j = 0; j < RAM_LEN; j++) begin
            tick(name, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, dir, 1'b0);
            words.push_back(ram_sdo);
        end
        tick(name, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // ff chain order at the output: last slice first, pointer before accumulator.
    function automatic void ff_image();
        expected.delete();
        for (int s = `EMU_SLICES - 1; s >= 0; s--) begin
            expected.push_back(emu_word_t'(m_ptr[s]));
            expected.push_back(emu_word_t'(m_acc[s][`EMU_RAM_ADDR_WIDTH-1:0]));
        end
    endfunction

    function automatic void ram_image();
        expected.delete();
        for (int s = `EMU_SLICES - 1; s >= 0; s--) begin
            for (int a = 0; a < `EMU_RAM_DEPTH; a++) expected.push_back(m_mem[s][a]);
        end
    endfunction

    task automatic compare_words(input string name);
        for (int j = 0; j < expected.size(); j++) check(name, expected[j], words[j]);
    endtask

    // ##############################
    // test sequence
    // ##############################

    initial begin
        int                          len;
        int                          overrides;
        logic                        hold_prev;
        logic [`EMU_COUNT_WIDTH-1:0] start;
        emu_word_t                   bits;
        overrides = 0;
        hold_prev = 1'b1;
        reset = 1'b1;
        {target_rst, run_mode, scan_mode, ff_scan, ff_dir} = '0;
        {ram_scan_reset, ram_scan, ram_dir} = '0;
        ff_sdi = '0;
        ram_sdi = '0;
        repeat (3) @(posedge host_clk);
        reset <= 1'b0;
        model_reset();
        @(negedge host_clk);
        check("reset idle", 64'd1, emu_word_t'(idle));
        check("reset cycle_count", '0, emu_word_t'(cycle_count));
        expected.delete();
        repeat (FF_LEN) expected.push_back('0);
        scan_ff("reset_scan", 1'b0);
        compare_words("reset_scan");

        for (int b = 0; b < BURSTS; b++) begin
            start = m_count;
            len = 1 + int'(take_bits(4));
            repeat (len) tick("run_burst", 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            tick("run_burst", 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            check("run_burst count", emu_word_t'(start + len), emu_word_t'(cycle_count));
        end
        ff_image();
        scan_ff("ff_scan", 1'b0);
        compare_words("ff_scan");
        ff_image();
        scan_ff("ff_rescan", 1'b0);
        compare_words("ff_rescan");

        ram_image();
        scan_ram("ram_scan", 1'b0);
        compare_words("ram_scan");

        // load new state from outside, run it, then read it back.
        scan_ff("ff_load", 1'b1);
        scan_ram("ram_load", 1'b1);
        repeat (8) tick("load_run", 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        tick("load_run", 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        ff_image();
        scan_ff("load_ff_out", 1'b0);
        compare_words("load_ff_out");
        ram_image();
        scan_ram("load_ram_out", 1'b0);
        compare_words("load_ram_out");

        ram_image();  // target reset must leave these.
        tick("target_rst", 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        tick("target_rst", 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        check("target_rst count", '0, emu_word_t'(cycle_count));
        scan_ram("rst_ram_out", 1'b0);
        compare_words("rst_ram_out");
        expected.delete();
        repeat (FF_LEN) expected.push_back('0);
        scan_ff("rst_ff_out", 1'b0);
        compare_words("rst_ff_out");

        for (int c = 0; c < MIX_LEN; c++) begin
            bits = take_bits(6);
            tick("mix", 1'b0, bits[0], bits[1], bits[2], bits[3], bits[4], bits[5]);
            check("mix idle", emu_word_t'(hold_prev), emu_word_t'(idle));
            hold_prev = bits[1] ? !(bits[2] || bits[3]) : !bits[0];
            if (bits[0] && bits[1] && !bits[2] && !bits[3]) overrides++;
        end
        tick("mix", 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        check("mix idle", emu_word_t'(hold_prev), emu_word_t'(idle));
        if (overrides == 0) begin
            errors++;
            $display("the mix never held scan_mode and run_mode high together");
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(PLANNED * 8 + 400);
        $display("timeout, the tests did not finish in %0d ns", PLANNED * 8 + 400);
        $display("Errors found");
        $finish;
    end

endmodule

// File: testbench/emu_ref_pkg.sv
`include "emu_settings.svh"

package emu_ref_pkg;
    import emu_pkg::*;

    // ##############################
    // random source
    // ##############################

    logic [15:0] lfsr_state = 16'd98;

    // fibonacci form, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic emu_word_t take_bits(input int n);
        emu_word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[`EMU_WORD_WIDTH-2:0], lfsr_bit()};  // one step per bit.
        end
        return v;
    endfunction

    // ##############################
    // reference model
    // ##############################

    emu_word_t                   m_acc [`EMU_SLICES];
    emu_ram_addr_t               m_ptr [`EMU_SLICES];
    emu_word_t                   m_mem [`EMU_SLICES][`EMU_RAM_DEPTH];
    emu_ram_addr_t               m_addr;
    logic                        m_idle;
    logic [`EMU_COUNT_WIDTH-1:0] m_count;

    function automatic void model_reset();
        for (int s = 0; s < `EMU_SLICES; s++) begin
            m_acc[s] = '0;
            m_ptr[s] = '0;
            for (int a = 0; a < `EMU_RAM_DEPTH; a++) begin
                m_mem[s][a] = '0;
            end
        end
        m_addr  = '0;
        m_idle  = 1'b1;
        m_count = '0;
    endfunction

    // target reset first, then scan, then run.
    function automatic emu_op_e expected_op(input logic t_rst, input logic run,
                                            input logic scan, input logic ffs,
                                            input logic rams);
        if (t_rst) return OP_TARGET_RESET;
        if (scan) begin
            if (ffs) return OP_FF_SHIFT;
            if (rams) return OP_RAM_SHIFT;
            return OP_HOLD;
        end
        if (run) return OP_STEP;
        return OP_HOLD;
    endfunction

    function automatic void model_step(input emu_op_e op, input logic ff_dir,
                                       input emu_word_t ff_sdi, input logic ram_dir,
                                       input emu_word_t ram_sdi, input logic addr_clear);
        emu_word_t     feed;
        emu_ram_addr_t a;
        a = m_addr;
        case (op)
            OP_STEP: begin
                for (int s = 0; s < `EMU_SLICES; s++) begin
                    feed = m_acc[s];
                    m_acc[s] = m_acc[s] + m_mem[s][m_ptr[s]] + emu_word_t'(s + 1);
                    m_mem[s][m_ptr[s]] = feed;
                    m_ptr[s] = emu_ram_addr_t'((m_ptr[s] + 1) % `EMU_RAM_DEPTH);
                end
            end
            OP_TARGET_RESET: begin
                for (int s = 0; s < `EMU_SLICES; s++) begin
                    m_acc[s] = '0;
                    m_ptr[s] = '0;
                end
            end
            OP_FF_SHIFT: begin
                feed = ff_dir ? ff_sdi : emu_word_t'(m_ptr[`EMU_SLICES-1]);
                // walk from the output end so every slice sees old values.
                for (int s = `EMU_SLICES - 1; s >= 0; s--) begin
                    m_ptr[s] = m_acc[s][`EMU_RAM_ADDR_WIDTH-1:0];
                    if (s == 0) m_acc[s] = feed;
                    else m_acc[s] = emu_word_t'(m_ptr[s-1]);
                end
            end
            OP_RAM_SHIFT: begin
                feed = ram_dir ? ram_sdi : m_mem[`EMU_SLICES-1][a];
                for (int s = `EMU_SLICES - 1; s > 0; s--) begin
                    m_mem[s][a] = m_mem[s-1][a];
                end
                m_mem[0][a] = feed;
            end
            default: ;
        endcase
        if (addr_clear) m_addr = '0;
        else if (op == OP_RAM_SHIFT) m_addr = emu_ram_addr_t'((a + 1) % `EMU_RAM_DEPTH);
        if (op == OP_TARGET_RESET) m_count = '0;
        else if (op == OP_STEP) m_count = m_count + 1'b1;
        m_idle = (op == OP_HOLD);
    endfunction

endpackage

// File: hdl/emu_top.sv
`timescale 1ns/1ns
`include "emu_settings.svh"

module emu_top (
    input  logic                        host_clk,
    input  logic                        reset,
    input  logic                        target_rst,
    input  logic                        run_mode,
    input  logic                        scan_mode,
    input  logic                        ff_scan,
    input  logic                        ff_dir,
    input  emu_pkg::emu_word_t          ff_sdi,
    output emu_pkg::emu_word_t          ff_sdo,
    input  logic                        ram_scan_reset,
    input  logic                        ram_scan,
    input  logic                        ram_dir,
    input  emu_pkg::emu_word_t          ram_sdi,
    output emu_pkg::emu_word_t          ram_sdo,
    output logic                        idle,
    output logic [`EMU_COUNT_WIDTH-1:0] cycle_count
);
    import emu_pkg::*;

    emu_ctrl_if ctrl ();

    // slice outputs, index 0 is the slice nearest the scan input.
    emu_word_t ff_chain  [`EMU_SLICES];
    emu_word_t ram_chain [`EMU_SLICES];

    emu_sequencer sequencer_i (
        .host_clk       (host_clk),
        .reset          (reset),
        .target_rst     (target_rst),
        .run_mode       (run_mode),
        .scan_mode      (scan_mode),
        .ff_scan        (ff_scan),
        .ff_dir         (ff_dir),
        .ff_sdi         (ff_sdi),
        .ff_loop        (ff_sdo),
        .ram_scan_reset (ram_scan_reset),
        .ram_scan       (ram_scan),
        .ram_dir        (ram_dir),
        .ram_sdi        (ram_sdi),
        .ram_loop       (ram_sdo),
        .ctrl           (ctrl.sequencer)
    );

    // ##############################
    // slice chain
    // ##############################

    for (genvar i = 0; i < `EMU_SLICES; i++) begin : g_slice
        emu_word_t ff_link;
        emu_word_t ram_link;

        if (i == 0) begin : g_head
            assign ff_link  = ctrl.ff_word;
            assign ram_link = ctrl.ram_word;
        end else begin : g_next
            assign ff_link  = ff_chain[i-1];
            assign ram_link = ram_chain[i-1];
        end

        emu_slice #(
            .SLICE_INDEX (i)
        ) slice_i (
            .host_clk (host_clk),
            .reset    (reset),
            .ctrl     (ctrl.target),
            .ff_in    (ff_link),
            .ram_in   (ram_link),
            .ff_out   (ff_chain[i]),
            .ram_out  (ram_chain[i])
        );
    end

    emu_status status_i (
        .host_clk    (host_clk),
        .reset       (reset),
        .ctrl        (ctrl.status),
        .ff_head     (ff_chain[`EMU_SLICES-1]),
        .ram_head    (ram_chain[`EMU_SLICES-1]),
        .ff_sdo      (ff_sdo),
        .ram_sdo     (ram_sdo),
        .idle        (idle),
        .cycle_count (cycle_count)
    );

endmodule

// File: hdl/emu_status.sv
`timescale 1ns/1ns
`include "emu_settings.svh"

module emu_status (
    input  logic                        host_clk,
    input  logic                        reset,
    emu_ctrl_if.status                  ctrl,
    input  emu_pkg::emu_word_t          ff_head,
    input  emu_pkg::emu_word_t          ram_head,
    output emu_pkg::emu_word_t          ff_sdo,
    output emu_pkg::emu_word_t          ram_sdo,
    output logic                        idle,
    output logic [`EMU_COUNT_WIDTH-1:0] cycle_count
);
    import emu_pkg::*;

    // chain heads are visible without a register stage.
    assign ff_sdo  = ff_head;
    assign ram_sdo = ram_head;

    // ##############################
    // step counter
    // ##############################

    always_ff @(posedge host_clk) begin
        if (reset || ctrl.op == OP_TARGET_RESET) begin
            cycle_count <= '0;
        end else if (ctrl.op == OP_STEP) begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // ##############################
    // idle flag
    // ##############################

    // reflects the op of the previous cycle.
    always_ff @(posedge host_clk) begin
        if (reset) begin
            idle <= 1'b1;
        end else begin
            idle <= (ctrl.op == OP_HOLD);
        end
    end

endmodule

// File: hdl/emu_slice.sv
`timescale 1ns/1ns
`include "emu_settings.svh"

module emu_slice #(
    parameter int SLICE_INDEX = 0
) (
    input  logic               host_clk,
    input  logic               reset,
    emu_ctrl_if.target         ctrl,
    input  emu_pkg::emu_word_t ff_in,
    input  emu_pkg::emu_word_t ram_in,
    output emu_pkg::emu_word_t ff_out,
    output emu_pkg::emu_word_t ram_out
);
    import emu_pkg::*;

    localparam emu_word_t     STEP_INC  = emu_word_t'(SLICE_INDEX + 1);
    localparam emu_ram_addr_t LAST_ADDR = emu_ram_addr_t'(`EMU_RAM_DEPTH - 1);

    // ##############################
    // target state
    // ##############################

    emu_word_t     acc;
    emu_ram_addr_t ptr;
    emu_word_t     mem [`EMU_RAM_DEPTH];

    emu_word_t     mem_at_ptr;
    emu_ram_addr_t ptr_next;

    assign mem_at_ptr = mem[ptr];
    assign ptr_next   = (ptr == LAST_ADDR) ? '0 : ptr + 1'b1;

    // ##############################
    // accumulator and pointer
    // ##############################

    always_ff @(posedge host_clk) begin
        if (reset) begin
            acc <= '0;
            ptr <= '0;
        end else begin
            case (ctrl.op)
                OP_STEP: begin
                    acc <= acc + mem_at_ptr + STEP_INC;  // wraps at the word width.
                    ptr <= ptr_next;
                end
                OP_TARGET_RESET: begin
                    acc <= '0;
                    ptr <= '0;
                end
                OP_FF_SHIFT: begin
                    // acc is the input side, ptr the output side of this slice.
                    acc <= ff_in;
                    ptr <= acc[`EMU_RAM_ADDR_WIDTH-1:0];
                end
                default: begin
                    acc <= acc;
                    ptr <= ptr;
                end
            endcase
        end
    end

    // ##############################
    // slice ram
    // ##############################

    always_ff @(posedge host_clk) begin
        if (reset) begin
            for (int w = 0; w < `EMU_RAM_DEPTH; w++) begin
                mem[w] <= '0;
            end
        end else if (ctrl.op == OP_STEP) begin
            mem[ptr] <= acc;                     // old acc, before this step.
        end else if (ctrl.op == OP_RAM_SHIFT) begin
            mem[ctrl.ram_addr] <= ram_in;
        end
    end

    // the pointer leaves the chain zero extended.
    assign ff_out  = emu_word_t'(ptr);
    assign ram_out = mem[ctrl.ram_addr];

endmodule

// File: hdl/emu_sequencer.sv
`timescale 1ns/1ns
`include "emu_settings.svh"

module emu_sequencer (
    input  logic               host_clk,
    input  logic               reset,
    input  logic               target_rst,
    input  logic               run_mode,
    input  logic               scan_mode,
    input  logic               ff_scan,
    input  logic               ff_dir,
    input  emu_pkg::emu_word_t ff_sdi,
    input  emu_pkg::emu_word_t ff_loop,
    input  logic               ram_scan_reset,
    input  logic               ram_scan,
    input  logic               ram_dir,
    input  emu_pkg::emu_word_t ram_sdi,
    input  emu_pkg::emu_word_t ram_loop,
    emu_ctrl_if.sequencer      ctrl
);
    import emu_pkg::*;

    localparam emu_ram_addr_t LAST_ADDR = emu_ram_addr_t'(`EMU_RAM_DEPTH - 1);

    emu_op_e       op;
    emu_ram_addr_t ram_addr;

    // ##############################
    // opcode decode
    // ##############################

    // target reset wins, then scan, then run.
    always_comb begin
        if (target_rst) begin
            op = OP_TARGET_RESET;
        end else if (scan_mode) begin
            if (ff_scan) begin
                op = OP_FF_SHIFT;
            end else if (ram_scan) begin
                op = OP_RAM_SHIFT;
            end else begin
                op = OP_HOLD;
            end
        end else if (run_mode) begin
            op = OP_STEP;
        end else begin
            op = OP_HOLD;
        end
    end

    // ##############################
    // ram scan address
    // ##############################

    always_ff @(posedge host_clk) begin
        if (reset) begin
            ram_addr <= '0;
        end else if (scan_mode && ram_scan_reset) begin
            ram_addr <= '0;
        end else if (op == OP_RAM_SHIFT) begin
            // wraps after the last word of a slice.
            if (ram_addr == LAST_ADDR) begin
                ram_addr <= '0;
            end else begin
                ram_addr <= ram_addr + 1'b1;
            end
        end
    end

    assign ctrl.op       = op;
    assign ctrl.ram_addr = ram_addr;

    // low dir recirculates the chain output for a non-destructive scan.
    assign ctrl.ff_word  = ff_dir ? ff_sdi : ff_loop;
    assign ctrl.ram_word = ram_dir ? ram_sdi : ram_loop;

endmodule

// File: hdl/emu_ctrl_if.sv
`timescale 1ns/1ns

interface emu_ctrl_if;
    import emu_pkg::*;

    // decoded operation, same for every slice.
    emu_op_e       op;

    // ram scan address shared by all slices.
    emu_ram_addr_t ram_addr;

    // words entering the head slice of each chain.
    emu_word_t     ff_word;
    emu_word_t     ram_word;

    modport sequencer (
        output op,
        output ram_addr,
        output ff_word,
        output ram_word
    );

    modport target (
        input  op,
        input  ram_addr,
        input  ff_word,
        input  ram_word
    );

    // the status block only needs to see what happened.
    modport status (
        input  op
    );

endinterface

// File: hdl/emu_pkg.sv
`include "emu_settings.svh"

package emu_pkg;

    // ##############################
    // data types
    // ##############################

    // one scan or data word.
    typedef logic [`EMU_WORD_WIDTH-1:0] emu_word_t;

    // address into a slice ram.
    typedef logic [`EMU_RAM_ADDR_WIDTH-1:0] emu_ram_addr_t;

    // ##############################
    // per-cycle operation
    // ##############################

    typedef enum logic [2:0] {
        OP_HOLD         = 3'd0,     // target frozen, no scan.
        OP_STEP         = 3'd1,     // one target clock step.
        OP_TARGET_RESET = 3'd2,     // target registers back to zero.
        OP_FF_SHIFT     = 3'd3,     // ff chain moves by one word.
        OP_RAM_SHIFT    = 3'd4      // ram chain moves by one word.
    } emu_op_e;

endpackage

// File: include/emu_settings.svh
`ifndef EMU_SETTINGS_SVH
`define EMU_SETTINGS_SVH

// ##############################
// harness dimensions
// ##############################

// number of identical target slices.
`define EMU_SLICES          4

// width of a scan word and of a target data word.
`define EMU_WORD_WIDTH      64

// words in each slice ram.
`define EMU_RAM_DEPTH       4
`define EMU_RAM_ADDR_WIDTH  2

// width of the target step counter.
`define EMU_COUNT_WIDTH     32

`endif
